/* Makefile */
SRCS := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

all: run

obj_dir/Vcache_tb: $(SRCS) src.f
	verilator --binary --timing --assert -f src.f --top-module cache_tb -o Vcache_tb

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* bench/cache_properties.sv */
`default_nettype none

module cache_properties (
    input wire logic                        clk,
    input wire logic                        proc_reset,
    input wire logic                        proc_stall,
    input wire logic                        mem_read,
    input wire logic                        mem_write,
    input wire logic                        mem_ready,
    input wire cache_addr_pkg::block_addr_t mem_addr
);

    // one kind of memory request at a time
    no_dual_request: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    // a waiting request keeps its address and kind
    request_held: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready
        |=> $stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
        else $error("memory request changed before mem_ready");

    // processor waits while memory is busy
    stall_on_request: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) |-> proc_stall)
        else $error("memory request without proc_stall");

endmodule

bind cache_top cache_properties i_cache_properties (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_stall (proc_stall),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_ready  (mem_ready),
    .mem_addr   (mem_addr)
);

`default_nettype wire

/* bench/cache_tb.sv */
`default_nettype none

`include "cache_cfg.svh"

module cache_tb;

    typedef struct {
        logic                        is_write;
        cache_addr_pkg::proc_addr_t  addr;
        cache_data_pkg::word_t       wdata;
        logic                        exp_hit;
        logic                        exp_wb;
        cache_addr_pkg::block_addr_t wb_addr;
    } step_t;

    localparam logic op_rd = 1'b0;
    localparam logic op_wr = 1'b1;
    localparam logic is_hit = 1'b1;
    localparam logic is_miss = 1'b0;
    localparam logic wb_yes = 1'b1;
    localparam logic wb_no = 1'b0;

    logic clk;
    logic proc_reset;
    logic proc_read;
    logic proc_write;
    cache_addr_pkg::proc_addr_t proc_addr;
    cache_data_pkg::word_t proc_wdata;
    cache_data_pkg::block_t mem_rdata;
    logic mem_ready;
    logic proc_stall;
    cache_data_pkg::word_t proc_rdata;
    logic mem_read;
    logic mem_write;
    cache_addr_pkg::block_addr_t mem_addr;
    cache_data_pkg::block_t mem_wdata;

    // memory model, shadow words and write-back log
    cache_data_pkg::block_t mem_blocks [cache_addr_pkg::block_addr_t];
    cache_data_pkg::word_t shadow [cache_addr_pkg::proc_addr_t];
    cache_addr_pkg::block_addr_t wb_log [$];
    step_t steps [$];

    logic mem_busy;
    int unsigned mem_wait;
    cache_addr_pkg::block_addr_t req_addr;
    logic table_ready;
    int errors;
    int checks;

    always #10 clk = ~clk;

    cache_top i_cache_top (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    // power-up word built from every address bit
    function automatic cache_data_pkg::word_t init_word(input cache_addr_pkg::proc_addr_t a);
        return {a, 2'b01} ^ 32'h1357_9bdf;
    endfunction

    function automatic cache_data_pkg::block_t read_block(input cache_addr_pkg::block_addr_t b);
        cache_data_pkg::block_t blk;
        if (mem_blocks.exists(b)) begin
            blk = mem_blocks[b];
        end else begin
            for (int w = 0; w < `CACHE_WORDS; w++) begin
                blk[w * `CACHE_WORD_W +: `CACHE_WORD_W] =
                    init_word({b, cache_addr_pkg::offset_t'(w)});
            end
        end
        return blk;
    endfunction

    function automatic cache_data_pkg::word_t expected_word(input cache_addr_pkg::proc_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic cache_addr_pkg::proc_addr_t make_addr(input cache_addr_pkg::tag_t t,
            input cache_addr_pkg::index_t i, input cache_addr_pkg::offset_t o);
        return {t, i, o};
    endfunction

    // answers a request 1 to 4 cycles after it is seen
    always @(posedge clk) begin
        if (mem_ready && (mem_read || mem_write)) begin
            if (mem_write) begin
                mem_blocks[mem_addr] = mem_wdata;
                wb_log.push_back(mem_addr);
            end
        end else if ((mem_read || mem_write) && !mem_busy && !proc_reset) begin
            mem_busy = 1'b1;
            mem_wait = $urandom % 4;
            req_addr = mem_addr;
        end
        #2;
        if (proc_reset) begin
            mem_ready = 1'b0;
            mem_busy = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                mem_busy = 1'b0;
                mem_rdata = read_block(req_addr);
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    task automatic add_step(input logic is_write, input cache_addr_pkg::proc_addr_t addr,
            input cache_data_pkg::word_t wdata, input logic exp_hit, input logic exp_wb,
            input cache_addr_pkg::block_addr_t wb_addr);
        step_t s;
        s.is_write = is_write;
        s.addr = addr;
        s.wdata = wdata;
        s.exp_hit = exp_hit;
        s.exp_wb = exp_wb;
        s.wb_addr = wb_addr;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // set 1 gets a cold read, hits, a write hit and a write-allocate into way 1
        add_step(op_rd, make_addr(26'h5, 2'd1, 2'd0), 32'h0, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h5, 2'd1, 2'd3), 32'h0, is_hit, wb_no, 28'h0);
        add_step(op_wr, make_addr(26'h5, 2'd1, 2'd2), 32'hdead_0001, is_hit, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h5, 2'd1, 2'd2), 32'h0, is_hit, wb_no, 28'h0);
        add_step(op_wr, make_addr(26'h9, 2'd1, 2'd1), 32'hbeef_0002, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h9, 2'd1, 2'd0), 32'h0, is_hit, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h9, 2'd1, 2'd1), 32'h0, is_hit, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h9, 2'd1, 2'd3), 32'h0, is_hit, wb_no, 28'h0);
        // in set 2 the third tag evicts the dirty first one
        add_step(op_wr, make_addr(26'h11, 2'd2, 2'd0), 32'h0bad_f00d, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h22, 2'd2, 2'd1), 32'h0, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h33, 2'd2, 2'd2), 32'h0, is_miss, wb_yes, {26'h11, 2'd2});
        add_step(op_rd, make_addr(26'h11, 2'd2, 2'd0), 32'h0, is_miss, wb_no, 28'h0);
        // A B A C in set 3 makes B the victim
        add_step(op_rd, make_addr(26'h40, 2'd3, 2'd0), 32'h0, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h50, 2'd3, 2'd1), 32'h0, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h40, 2'd3, 2'd2), 32'h0, is_hit, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h60, 2'd3, 2'd3), 32'h0, is_miss, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h40, 2'd3, 2'd0), 32'h0, is_hit, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h50, 2'd3, 2'd0), 32'h0, is_miss, wb_no, 28'h0);
        add_step(op_wr, make_addr(26'h40, 2'd3, 2'd1), 32'h1234_5678, is_hit, wb_no, 28'h0);
        add_step(op_rd, make_addr(26'h40, 2'd3, 2'd1), 32'h0, is_hit, wb_no, 28'h0);
    endtask

    task automatic check_idle_outputs();
        checks++;
        if (proc_stall || mem_read || mem_write) begin
            errors++;
            $display("MISMATCH %0t: idle outputs stall %0b read %0b write %0b", $time,
                proc_stall, mem_read, mem_write);
        end
    endtask

    // called 2 units after a rising edge
    task automatic run_access(input step_t s, input int idx);
        logic hit_seen;
        cache_data_pkg::word_t exp;
        wb_log.delete();
        proc_addr = s.addr;
        proc_wdata = s.wdata;
        proc_read = !s.is_write;
        proc_write = s.is_write;
        @(negedge clk);
        hit_seen = !proc_stall;
        checks++;
        if (hit_seen != s.exp_hit) begin
            errors++;
            $display("MISMATCH %0t: step %0d hit %0b expected %0b", $time, idx,
                hit_seen, s.exp_hit);
        end
        if (hit_seen && (mem_read || mem_write)) begin
            errors++;
            $display("MISMATCH %0t: step %0d memory request on a hit", $time, idx);
        end
        while (proc_stall) begin
            @(negedge clk);
        end
        checks++;
        if (!s.is_write) begin
            exp = expected_word(s.addr);
            if (proc_rdata !== exp) begin
                errors++;
                $display("MISMATCH %0t: step %0d read %h got %h expected %h", $time, idx,
                    s.addr, proc_rdata, exp);
            end
        end else begin
            shadow[s.addr] = s.wdata;
        end
        checks++;
        if (s.exp_wb) begin
            if (wb_log.size() != 1) begin
                errors++;
                $display("MISMATCH %0t: step %0d %0d write-backs, expected 1", $time, idx,
                    wb_log.size());
            end else if (wb_log[0] != s.wb_addr) begin
                errors++;
                $display("MISMATCH %0t: step %0d write-back to %h expected %h", $time, idx,
                    wb_log[0], s.wb_addr);
            end
        end else if (wb_log.size() != 0) begin
            errors++;
            $display("MISMATCH %0t: step %0d unexpected write-back", $time, idx);
        end
        @(posedge clk);
        #2;
        proc_read = 1'b0;
        proc_write = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h5862_511e));
        clk = 1'b0;
        proc_reset = 1'b1;
        proc_read = 1'b0;
        proc_write = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        mem_busy = 1'b0;
        mem_wait = 0;
        req_addr = '0;
        errors = 0;
        checks = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        proc_reset = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        #2;
        for (int i = 0; i < steps.size(); i++) begin
            run_access(steps[i], i);
        end
        @(negedge clk);
        check_idle_outputs();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (steps.size() * 20 + 50) @(posedge clk);
        $display("timeout: the access table did not complete in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cache_addr_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_addr_pkg;

    // full processor word address
    typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] proc_addr_t;

    // address fields
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // memory side block address, tag then index
    typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] block_addr_t;

endpackage

`default_nettype wire

/* hw/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// processor word and memory block widths
`define CACHE_WORD_W 32
`define CACHE_BLOCK_W 128

// address split of a 30-bit word address
// tag | index | offset
`define CACHE_TAG_W 26
`define CACHE_INDEX_W 2
`define CACHE_OFFSET_W 2

// geometry
`define CACHE_SETS 4
`define CACHE_WORDS 4

`endif

/* hw/cache_controller.sv */
`default_nettype none

`include "cache_cfg.svh"

module cache_controller (
    input  wire logic                   clk,
    input  wire logic                   proc_reset,
    input  wire logic                   proc_read,
    input  wire logic                   proc_write,
    input  wire cache_addr_pkg::proc_addr_t proc_addr,
    input  wire cache_data_pkg::word_t  proc_wdata,
    input  wire logic                   mem_ready,
    input  wire cache_data_pkg::block_t mem_rdata,
    input  wire logic                   hit0,
    input  wire logic                   hit1,
    input  wire logic                   valid0,
    input  wire logic                   valid1,
    input  wire logic                   dirty0,
    input  wire logic                   dirty1,
    input  wire cache_addr_pkg::tag_t   line_tag0,
    input  wire cache_addr_pkg::tag_t   line_tag1,
    input  wire cache_data_pkg::block_t line_data0,
    input  wire cache_data_pkg::block_t line_data1,
    input  wire cache_data_pkg::word_t  word0,
    input  wire cache_data_pkg::word_t  word1,
    output logic                        proc_stall,
    output cache_data_pkg::word_t       proc_rdata,
    output logic                        mem_read,
    output logic                        mem_write,
    output cache_addr_pkg::block_addr_t mem_addr,
    output cache_data_pkg::block_t      mem_wdata,
    output cache_addr_pkg::index_t      index,
    output cache_addr_pkg::tag_t        tag,
    output cache_addr_pkg::offset_t     offset,
    output cache_data_pkg::word_t       wdata,
    output logic                        word_we0,
    output logic                        word_we1,
    output logic                        fill_we0,
    output logic                        fill_we1,
    output cache_data_pkg::block_t      fill_data
);

    cache_data_pkg::ctrl_state_t state;
    cache_data_pkg::ctrl_state_t state_next;

    // one bit per set naming the least recently used way
    logic [`CACHE_SETS-1:0] lru;
    logic lru_we;
    cache_data_pkg::way_sel_t lru_next;

    logic request;
    logic hit;
    cache_data_pkg::way_sel_t hit_way;
    cache_data_pkg::way_sel_t victim;
    logic victim_dirty;
    cache_addr_pkg::tag_t victim_tag;
    cache_addr_pkg::block_addr_t victim_addr;

    // address split
    assign {tag, index, offset} = proc_addr;
    assign wdata = proc_wdata;
    assign fill_data = mem_rdata;

    assign request = proc_read || proc_write;

    // at most one way matches a tag in a set
    assign hit = hit0 || hit1;
    assign hit_way = hit1;

    // the filled way hits in the output cycle and supplies the word
    assign proc_rdata = hit1 ? word1 : word0;

    // victim is the first invalid way or else the LRU way
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else begin
            victim = lru[index];
        end
    end

    assign victim_dirty = victim ? (valid1 && dirty1) : (valid0 && dirty0);
    assign victim_tag = victim ? line_tag1 : line_tag0;
    assign victim_addr = {victim_tag, index};
    assign mem_wdata = victim ? line_data1 : line_data0;

    // miss sequence and strobes
    always_comb begin
        state_next = state;
        proc_stall = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_addr = {tag, index};
        word_we0 = 1'b0;
        word_we1 = 1'b0;
        fill_we0 = 1'b0;
        fill_we1 = 1'b0;
        lru_we = 1'b0;
        lru_next = 1'b0;

        case (state)
            cache_data_pkg::ST_IDLE: begin
                if (request && hit) begin
                    word_we0 = proc_write && hit0;
                    word_we1 = proc_write && hit1;
                    lru_we = 1'b1;
                    lru_next = ~hit_way;
                end else if (request) begin
                    proc_stall = 1'b1;
                    if (victim_dirty) begin
                        mem_write = 1'b1;
                        mem_addr = victim_addr;
                        state_next = cache_data_pkg::ST_WRITE_BACK;
                    end else begin
                        mem_read = 1'b1;
                        state_next = cache_data_pkg::ST_ALLOCATE;
                    end
                end
            end

            cache_data_pkg::ST_WRITE_BACK: begin
                proc_stall = 1'b1;
                mem_write = 1'b1;
                mem_addr = victim_addr;
                if (mem_ready) begin
                    state_next = cache_data_pkg::ST_ALLOCATE;
                end
            end

            cache_data_pkg::ST_ALLOCATE: begin
                proc_stall = 1'b1;
                mem_read = 1'b1;
                if (mem_ready) begin
                    fill_we0 = !victim;
                    fill_we1 = victim;
                    // on a write miss the word goes in with the fill
                    word_we0 = proc_write && !victim;
                    word_we1 = proc_write && victim;
                    lru_we = 1'b1;
                    lru_next = ~victim;
                    state_next = cache_data_pkg::ST_OUTPUT;
                end
            end

            cache_data_pkg::ST_OUTPUT: begin
                state_next = cache_data_pkg::ST_IDLE;
            end

            default: begin
                state_next = cache_data_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= cache_data_pkg::ST_IDLE;
            lru <= '0;
        end else begin
            state <= state_next;
            if (lru_we) begin
                lru[index] <= lru_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cache_data_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_data_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_BLOCK_W-1:0] block_t;

    // way 0 or way 1
    typedef logic way_sel_t;

    // miss handling states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_BACK,
        ST_ALLOCATE,
        ST_OUTPUT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/cache_top.sv */
`default_nettype none

module cache_top (
    input  wire logic                   clk,
    input  wire logic                   proc_reset,
    input  wire logic                   proc_read,
    input  wire logic                   proc_write,
    input  wire cache_addr_pkg::proc_addr_t proc_addr,
    input  wire cache_data_pkg::word_t  proc_wdata,
    input  wire cache_data_pkg::block_t mem_rdata,
    input  wire logic                   mem_ready,
    output logic                        proc_stall,
    output cache_data_pkg::word_t       proc_rdata,
    output logic                        mem_read,
    output logic                        mem_write,
    output cache_addr_pkg::block_addr_t mem_addr,
    output cache_data_pkg::block_t      mem_wdata
);

    // request fields shared by both ways
    cache_addr_pkg::index_t index;
    cache_addr_pkg::tag_t tag;
    cache_addr_pkg::offset_t offset;
    cache_data_pkg::word_t wdata;
    cache_data_pkg::block_t fill_data;

    // per-way strobes and status
    logic word_we0;
    logic word_we1;
    logic fill_we0;
    logic fill_we1;
    logic hit0;
    logic hit1;
    logic valid0;
    logic valid1;
    logic dirty0;
    logic dirty1;
    cache_addr_pkg::tag_t line_tag0;
    cache_addr_pkg::tag_t line_tag1;
    cache_data_pkg::block_t line_data0;
    cache_data_pkg::block_t line_data1;
    cache_data_pkg::word_t word0;
    cache_data_pkg::word_t word1;

    cache_way i_way0 (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .tag        (tag),
        .offset     (offset),
        .word_we    (word_we0),
        .wdata      (wdata),
        .fill_we    (fill_we0),
        .fill_data  (fill_data),
        .hit        (hit0),
        .valid      (valid0),
        .dirty      (dirty0),
        .line_tag   (line_tag0),
        .line_data  (line_data0),
        .word       (word0)
    );

    cache_way i_way1 (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .tag        (tag),
        .offset     (offset),
        .word_we    (word_we1),
        .wdata      (wdata),
        .fill_we    (fill_we1),
        .fill_data  (fill_data),
        .hit        (hit1),
        .valid      (valid1),
        .dirty      (dirty1),
        .line_tag   (line_tag1),
        .line_data  (line_data1),
        .word       (word1)
    );

    cache_controller i_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .hit0       (hit0),
        .hit1       (hit1),
        .valid0     (valid0),
        .valid1     (valid1),
        .dirty0     (dirty0),
        .dirty1     (dirty1),
        .line_tag0  (line_tag0),
        .line_tag1  (line_tag1),
        .line_data0 (line_data0),
        .line_data1 (line_data1),
        .word0      (word0),
        .word1      (word1),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .index      (index),
        .tag        (tag),
        .offset     (offset),
        .wdata      (wdata),
        .word_we0   (word_we0),
        .word_we1   (word_we1),
        .fill_we0   (fill_we0),
        .fill_we1   (fill_we1),
        .fill_data  (fill_data)
    );

endmodule

`default_nettype wire

/* hw/cache_way.sv */
`default_nettype none

`include "cache_cfg.svh"

module cache_way (
    input  wire logic                   clk,
    input  wire logic                   proc_reset,
    input  wire cache_addr_pkg::index_t index,
    input  wire cache_addr_pkg::tag_t   tag,
    input  wire cache_addr_pkg::offset_t offset,
    input  wire logic                   word_we,
    input  wire cache_data_pkg::word_t  wdata,
    input  wire logic                   fill_we,
    input  wire cache_data_pkg::block_t fill_data,
    output logic                        hit,
    output logic                        valid,
    output logic                        dirty,
    output cache_addr_pkg::tag_t        line_tag,
    output cache_data_pkg::block_t      line_data,
    output cache_data_pkg::word_t       word
);

    // per-set storage
    logic [`CACHE_SETS-1:0] valid_mem;
    logic [`CACHE_SETS-1:0] dirty_mem;
    cache_addr_pkg::tag_t tag_mem [`CACHE_SETS];
    cache_data_pkg::block_t data_mem [`CACHE_SETS];

    cache_data_pkg::block_t next_line;

    // status of the looked-up set
    assign valid = valid_mem[index];
    assign dirty = dirty_mem[index];
    assign line_tag = tag_mem[index];
    assign line_data = data_mem[index];

    assign hit = valid && (line_tag == tag);

    // word select by offset
    assign word = line_data[offset * `CACHE_WORD_W +: `CACHE_WORD_W];

    // new line content with the word write on top of a fill
    always_comb begin
        next_line = fill_we ? fill_data : data_mem[index];
        for (int w = 0; w < `CACHE_WORDS; w++) begin
            if (word_we && (offset == cache_addr_pkg::offset_t'(w))) begin
                next_line[w * `CACHE_WORD_W +: `CACHE_WORD_W] = wdata;
            end
        end
    end

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_mem <= '0;
            dirty_mem <= '0;
        end else begin
            if (fill_we) begin
                valid_mem[index] <= 1'b1;
                dirty_mem[index] <= 1'b0;
            end
            // a word write always leaves the line dirty
            if (word_we) begin
                dirty_mem[index] <= 1'b1;
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index] <= tag;
        end
        if (fill_we || word_we) begin
            data_mem[index] <= next_line;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/cache_addr_pkg.sv
hw/cache_data_pkg.sv
hw/cache_way.sv
hw/cache_controller.sv
hw/cache_top.sv
bench/cache_properties.sv
bench/cache_tb.sv
